// ==== hdl/icache_pkg.sv ====
package icache_pkg;

        // Default geometry. 256 bytes of 16-byte lines gives 16 lines of 4 words.
        localparam int DEF_CACHE_SIZE = 256;
        localparam int DEF_CACHE_LINE = 16;

        // Controller states.
        typedef enum logic [2:0]
        {
                S_IDLE,
                S_LOOKUP,
                S_REFILL,
                S_UNCACHED,
                S_INVALIDATE
        } ctrl_state_t;

        // Wishbone registered feedback cycle types.
        typedef enum logic [2:0]
        {
                CTI_CLASSIC = 3'd0,
                CTI_INCR    = 3'd2,
                CTI_EOB     = 3'd7
        } cti_t;

endpackage

// ==== hdl/icache_array_if.sv ====
interface icache_array_if #(
        parameter int CACHE_SIZE = icache_pkg::DEF_CACHE_SIZE,
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
);

        localparam int IDX_W = $clog2(CACHE_SIZE / CACHE_LINE);
        localparam int OFF_W = $clog2(CACHE_LINE / 4);
        localparam int TAG_W = 32 - IDX_W - $clog2(CACHE_LINE);

        // Word index. The upper IDX_W bits select the line.
        logic [IDX_W+OFF_W-1:0] rd_idx;
        logic [TAG_W-1:0]       rd_tag;
        logic                   rd_valid;
        logic [31:0]            rd_word;

        // Writes go to the line selected by rd_idx.
        logic                   wr_en;
        logic [OFF_W-1:0]       wr_off;
        logic [31:0]            wr_word;
        logic [TAG_W-1:0]       wr_tag;
        logic                   set_valid;

        logic                   inv_req;
        logic                   inv_done;

        modport ctrl (output rd_idx, wr_en, wr_off, wr_word, wr_tag, set_valid, inv_req,
                      input  rd_tag, rd_valid, rd_word, inv_done);
        modport store (input  rd_idx, wr_en, wr_off, wr_word, wr_tag, set_valid, inv_req,
                       output rd_tag, rd_valid, rd_word, inv_done);

endinterface

// ==== hdl/icache_refill_if.sv ====
interface icache_refill_if #(
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
);

        localparam int OFF_W = $clog2(CACHE_LINE / 4);

        // Transfer request from the controller.
        logic                   start;
        logic [31:0]            start_addr;
        logic                   burst;

        // One pulse per received word.
        logic                   word_valid;
        logic [OFF_W-1:0]       word_off;
        logic [31:0]            word;

        // Exactly one of these ends a transfer.
        logic                   done;
        logic                   error;

        modport ctrl (output start, start_addr, burst,
                      input  word_valid, word_off, word, done, error);
        modport bus (input  start, start_addr, burst,
                     output word_valid, word_off, word, done, error);

endinterface

// ==== hdl/icache_req_stage.sv ====
module icache_req_stage (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_rd,
        input  logic [31:0]     i_address,
        input  logic            i_cache_inv_req,
        input  logic            i_take,
        output logic            o_req_valid,
        output logic [31:0]     o_req_addr,
        output logic            o_inv_pending
);

logic rd_q;
logic inv_q;
logic new_fetch;

// Only the first cycle of a held strobe counts as a new fetch.
assign new_fetch = i_rd && !rd_q && !o_req_valid;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                rd_q          <= 1'b0;
                inv_q         <= 1'b0;
                o_req_valid   <= 1'b0;
                o_inv_pending <= 1'b0;
        end
        else
        begin
                rd_q  <= i_rd;
                inv_q <= i_cache_inv_req;

                // A take frees the fetch first, as the controller serves it first.
                if (i_take && o_req_valid)
                        o_req_valid <= 1'b0;
                else if (new_fetch)
                        o_req_valid <= 1'b1;

                if (i_take && !o_req_valid)
                        o_inv_pending <= 1'b0;
                else if (i_cache_inv_req && !inv_q)
                        o_inv_pending <= 1'b1;
        end
end

// Address stays put until the CPU starts its next fetch.
always_ff @(posedge i_clk)
begin
        if (new_fetch)
                o_req_addr <= i_address;
end

endmodule

// ==== hdl/icache_line_store.sv ====
module icache_line_store #(
        parameter int CACHE_SIZE = icache_pkg::DEF_CACHE_SIZE,
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
) (
        input  logic            i_clk,
        input  logic            i_reset,
        icache_array_if.store   arr
);

localparam int NUM_LINES = CACHE_SIZE / CACHE_LINE;
localparam int WORDS     = CACHE_LINE / 4;
localparam int IDX_W     = $clog2(NUM_LINES);
localparam int OFF_W     = $clog2(WORDS);
localparam int TAG_W     = 32 - IDX_W - $clog2(CACHE_LINE);

logic [31:0]            data_mem [NUM_LINES*WORDS];
logic [TAG_W-1:0]       tag_mem  [NUM_LINES];
logic [NUM_LINES-1:0]   valid;
logic [IDX_W-1:0]       line;
logic [IDX_W-1:0]       sweep_idx;
logic                   sweeping;

assign line = arr.rd_idx[IDX_W+OFF_W-1:OFF_W];

// Synchronous read of tag, valid and word.
always_ff @(posedge i_clk)
begin
        arr.rd_word  <= data_mem[arr.rd_idx];
        arr.rd_tag   <= tag_mem[line];
        arr.rd_valid <= valid[line];
end

always_ff @(posedge i_clk)
begin
        if (arr.wr_en)
        begin
                data_mem[{line, arr.wr_off}] <= arr.wr_word;
                tag_mem[line]                <= arr.wr_tag;
        end
end

// The first word of a refill drops the line until the whole line is in.
always_ff @(posedge i_clk)
begin
        if (sweeping)
                valid[sweep_idx] <= 1'b0;
        else if (arr.set_valid)
                valid[line] <= 1'b1;
        else if (arr.wr_en)
                valid[line] <= 1'b0;
end

// Sweep one line per cycle, started by reset or by the controller.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                sweeping     <= 1'b1;
                sweep_idx    <= '0;
                arr.inv_done <= 1'b0;
        end
        else
        begin
                arr.inv_done <= 1'b0;
                if (sweeping)
                begin
                        sweep_idx <= sweep_idx + 1'b1;
                        if (&sweep_idx)
                        begin
                                sweeping     <= 1'b0;
                                arr.inv_done <= 1'b1;
                        end
                end
                else if (arr.inv_req && !arr.inv_done)
                begin
                        // Request is still high in the done cycle, so skip that one.
                        sweeping  <= 1'b1;
                        sweep_idx <= '0;
                end
        end
end

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl #(
        parameter int CACHE_SIZE = icache_pkg::DEF_CACHE_SIZE,
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
) (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_req_valid,
        input  logic [31:0]     i_req_addr,
        input  logic            i_inv_pending,
        output logic            o_take,
        input  logic            i_cache_en,
        output logic [31:0]     o_dat,
        output logic            o_ack,
        output logic            o_err,
        output logic            o_cache_inv_done,
        icache_array_if.ctrl    arr,
        icache_refill_if.ctrl   rf
);

localparam int IDX_W    = $clog2(CACHE_SIZE / CACHE_LINE);
localparam int OFF_W    = $clog2(CACHE_LINE / 4);
localparam int LINE_LSB = $clog2(CACHE_LINE);
localparam int TAG_LSB  = LINE_LSB + IDX_W;

icache_pkg::ctrl_state_t state;
icache_pkg::ctrl_state_t state_nxt;
logic                    hit;
logic                    xfer;
logic                    inv_user;
logic [31-TAG_LSB:0]     req_tag;
logic [OFF_W-1:0]        req_off;

assign req_tag = i_req_addr[31:TAG_LSB];
assign req_off = i_req_addr[LINE_LSB-1:2];
assign hit     = arr.rd_valid && (arr.rd_tag == req_tag);
assign xfer    = (state == icache_pkg::S_REFILL) || (state == icache_pkg::S_UNCACHED);

// The held request address indexes the store for the whole access.
assign arr.rd_idx    = i_req_addr[TAG_LSB-1:2];
assign arr.wr_en     = (state == icache_pkg::S_REFILL) && rf.word_valid;
assign arr.wr_off    = rf.word_off;
assign arr.wr_word   = rf.word;
assign arr.wr_tag    = req_tag;
assign arr.set_valid = (state == icache_pkg::S_REFILL) && rf.done;
assign arr.inv_req   = (state == icache_pkg::S_INVALIDATE);

always_comb
begin
        state_nxt     = state;
        o_take        = 1'b0;
        rf.start      = 1'b0;
        rf.burst      = 1'b0;
        rf.start_addr = {i_req_addr[31:2], 2'b00};
        case (state)
        icache_pkg::S_IDLE:
        begin
                // Fetches win over a pending invalidate.
                if (i_req_valid)
                begin
                        o_take = 1'b1;
                        if (i_cache_en)
                                state_nxt = icache_pkg::S_LOOKUP;
                        else
                        begin
                                rf.start  = 1'b1;
                                state_nxt = icache_pkg::S_UNCACHED;
                        end
                end
                else if (i_inv_pending)
                begin
                        o_take    = 1'b1;
                        state_nxt = icache_pkg::S_INVALIDATE;
                end
        end
        icache_pkg::S_LOOKUP:
        begin
                state_nxt = icache_pkg::S_IDLE;
                if (!hit)
                begin
                        rf.start      = 1'b1;
                        rf.burst      = 1'b1;
                        rf.start_addr = {i_req_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
                        state_nxt     = icache_pkg::S_REFILL;
                end
        end
        icache_pkg::S_REFILL, icache_pkg::S_UNCACHED:
        begin
                if (rf.done || rf.error)
                        state_nxt = icache_pkg::S_IDLE;
        end
        icache_pkg::S_INVALIDATE:
        begin
                if (arr.inv_done)
                        state_nxt = icache_pkg::S_IDLE;
        end
        default:
                state_nxt = icache_pkg::S_IDLE;
        endcase
end

// Reset parks in S_INVALIDATE while the store runs its power-on sweep.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state            <= icache_pkg::S_INVALIDATE;
                inv_user         <= 1'b0;
                o_ack            <= 1'b0;
                o_err            <= 1'b0;
                o_cache_inv_done <= 1'b0;
        end
        else
        begin
                state            <= state_nxt;
                o_ack            <= ((state == icache_pkg::S_LOOKUP) && hit) || (xfer && rf.done);
                o_err            <= xfer && rf.error;
                o_cache_inv_done <= arr.inv_req && arr.inv_done && inv_user;
                if ((state == icache_pkg::S_IDLE) && !i_req_valid && i_inv_pending)
                        inv_user <= 1'b1;
                else if (arr.inv_done)
                        inv_user <= 1'b0;
        end
end

// Refill keeps only the word the CPU asked for.
always_ff @(posedge i_clk)
begin
        if (state == icache_pkg::S_LOOKUP)
                o_dat <= arr.rd_word;
        else if (rf.word_valid && ((state == icache_pkg::S_UNCACHED) || (rf.word_off == req_off)))
                o_dat <= rf.word;
end

endmodule

// ==== hdl/icache_wb_master.sv ====
module icache_wb_master #(
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
) (
        input  logic                    i_clk,
        input  logic                    i_reset,
        icache_refill_if.bus            rf,
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic [31:0]             o_wb_adr,
        output icache_pkg::cti_t        o_wb_cti,
        output logic [3:0]              o_wb_sel,
        output logic                    o_wb_wen,
        input  logic [31:0]             i_wb_dat,
        input  logic                    i_wb_ack,
        input  logic                    i_wb_err
);

localparam int WORDS = CACHE_LINE / 4;
localparam int OFF_W = $clog2(WORDS);

logic [OFF_W-1:0]       beat;
logic                   burst_q;
logic                   last_beat;
logic                   beat_ack;
logic                   beat_err;

// Read only, always full words.
assign o_wb_sel  = 4'hF;
assign o_wb_wen  = 1'b0;

assign beat_err  = o_wb_stb && i_wb_err;
assign beat_ack  = o_wb_stb && i_wb_ack && !i_wb_err;
assign last_beat = !burst_q || (&beat);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_wb_cyc      <= 1'b0;
                o_wb_stb      <= 1'b0;
                o_wb_cti      <= icache_pkg::CTI_EOB;
                beat          <= '0;
                burst_q       <= 1'b0;
                rf.word_valid <= 1'b0;
                rf.done       <= 1'b0;
                rf.error      <= 1'b0;
        end
        else
        begin
                rf.word_valid <= beat_ack;
                rf.done       <= beat_ack && last_beat;
                rf.error      <= beat_err;
                if (rf.start)
                begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        burst_q  <= rf.burst;
                        beat     <= '0;
                        o_wb_cti <= rf.burst ? icache_pkg::CTI_INCR : icache_pkg::CTI_EOB;
                end
                else if (beat_err || (beat_ack && last_beat))
                begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_cti <= icache_pkg::CTI_EOB;
                end
                else if (beat_ack)
                begin
                        beat <= beat + 1'b1;
                        // The beat after this one closes the burst.
                        if (beat == OFF_W'(WORDS - 2))
                                o_wb_cti <= icache_pkg::CTI_EOB;
                        else
                                o_wb_cti <= icache_pkg::CTI_INCR;
                end
        end
end

always_ff @(posedge i_clk)
begin
        if (rf.start)
                o_wb_adr <= rf.start_addr;
        else if (beat_ack && !last_beat)
                o_wb_adr <= o_wb_adr + 32'd4;

        if (beat_ack)
        begin
                rf.word     <= i_wb_dat;
                rf.word_off <= beat;
        end
end

endmodule

// ==== hdl/icache_top.sv ====
module icache_top #(
        parameter int CACHE_SIZE = icache_pkg::DEF_CACHE_SIZE,
        parameter int CACHE_LINE = icache_pkg::DEF_CACHE_LINE
) (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_rd,
        input  logic [31:0]             i_address,
        input  logic                    i_cache_en,
        input  logic                    i_cache_inv_req,
        output logic [31:0]             o_dat,
        output logic                    o_ack,
        output logic                    o_err,
        output logic                    o_cache_inv_done,
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic [31:0]             o_wb_adr,
        output icache_pkg::cti_t        o_wb_cti,
        output logic [3:0]              o_wb_sel,
        output logic                    o_wb_wen,
        input  logic [31:0]             i_wb_dat,
        input  logic                    i_wb_ack,
        input  logic                    i_wb_err
);

logic           req_valid;
logic [31:0]    req_addr;
logic           inv_pending;
logic           take;

icache_array_if #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_array_if ();
icache_refill_if #(.CACHE_LINE(CACHE_LINE)) u_refill_if ();

// Input side.
icache_req_stage u_req_stage (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_rd            (i_rd),
        .i_address       (i_address),
        .i_cache_inv_req (i_cache_inv_req),
        .i_take          (take),
        .o_req_valid     (req_valid),
        .o_req_addr      (req_addr),
        .o_inv_pending   (inv_pending)
);

icache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_ctrl (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_req_valid      (req_valid),
        .i_req_addr       (req_addr),
        .i_inv_pending    (inv_pending),
        .o_take           (take),
        .i_cache_en       (i_cache_en),
        .o_dat            (o_dat),
        .o_ack            (o_ack),
        .o_err            (o_err),
        .o_cache_inv_done (o_cache_inv_done),
        .arr              (u_array_if.ctrl),
        .rf               (u_refill_if.ctrl)
);

icache_line_store #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_line_store (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .arr     (u_array_if.store)
);

// Output side.
icache_wb_master #(.CACHE_LINE(CACHE_LINE)) u_wb_master (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .rf       (u_refill_if.bus),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_adr (o_wb_adr),
        .o_wb_cti (o_wb_cti),
        .o_wb_sel (o_wb_sel),
        .o_wb_wen (o_wb_wen),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack),
        .i_wb_err (i_wb_err)
);

endmodule

// ==== tb/icache_tb_asserts.sv ====
module icache_wb_asserts (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            o_wb_cyc,
        input  logic            o_wb_stb,
        input  logic [31:0]     o_wb_adr,
        input  logic [2:0]      o_wb_cti,
        input  logic            i_wb_ack,
        input  logic            i_wb_err,
        input  logic            o_ack,
        input  logic            o_err
);

// A strobe is only legal inside a bus cycle.
stb_inside_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb |-> o_wb_cyc)
        else $error("o_wb_stb high without o_wb_cyc");

// A waiting beat keeps its address and cycle type.
beat_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_wb_stb && !i_wb_ack && !i_wb_err) |=>
        (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_cti)))
        else $error("o_wb_adr or o_wb_cti changed while a beat was waiting");

ack_err_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_ack && o_err))
        else $error("o_ack and o_err high in the same cycle");

endmodule

bind icache_top icache_wb_asserts u_wb_asserts (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_adr (o_wb_adr),
        .o_wb_cti (o_wb_cti),
        .i_wb_ack (i_wb_ack),
        .i_wb_err (i_wb_err),
        .o_ack    (o_ack),
        .o_err    (o_err)
);

// ==== tb/icache_tb.sv ====
module icache_tb;

localparam int          WORDS          = icache_pkg::DEF_CACHE_LINE / 4;
// Capture, array read and acknowledge.
localparam int          HIT_EDGES      = 3;
// About 35 reads of up to 30 cycles each, plus sweeps, with a wide margin.
localparam int          TIMEOUT_CYCLES = 3000;
localparam logic [31:0] DATA_PATTERN   = 32'hA5A5_0000;
localparam logic [31:0] ADDR_A         = 32'h0000_1238;
localparam logic [31:0] ADDR_ERR       = 32'h0000_2348;

logic                   i_clk;
logic                   i_reset;
logic                   i_rd;
logic [31:0]            i_address;
logic                   i_cache_en;
logic                   i_cache_inv_req;
logic [31:0]            o_dat;
logic                   o_ack;
logic                   o_err;
logic                   o_cache_inv_done;
logic                   o_wb_cyc;
logic                   o_wb_stb;
logic [31:0]            o_wb_adr;
icache_pkg::cti_t       o_wb_cti;
logic [3:0]             o_wb_sel;
logic                   o_wb_wen;
logic [31:0]            i_wb_dat;
logic                   i_wb_ack;
logic                   i_wb_err;

integer                 seed = 34770;
int                     errors;
int                     tests;
int                     cycle_count;
int                     wait_left;
int                     bursts;
logic                   cyc_q;
logic                   err_en;
logic [31:0]            err_addr;
logic [31:0]            beat_adr_q [$];
logic [2:0]             beat_cti_q [$];

// Result of the last fetch.
logic [31:0]            rd_data;
logic                   rd_acked;
logic                   rd_erred;
logic                   rd_cyc_seen;
int                     rd_edges;

icache_top #(
        .CACHE_SIZE (icache_pkg::DEF_CACHE_SIZE),
        .CACHE_LINE (icache_pkg::DEF_CACHE_LINE)
) i_dut (.*);

always #4 i_clk = ~i_clk;

// Memory model with 0 to 3 wait states per beat.
always @(posedge i_clk)
begin
        cyc_q <= o_wb_cyc;
        if (o_wb_cyc === 1'b1 && cyc_q !== 1'b1)
                bursts = bursts + 1;
        if (i_wb_ack || i_wb_err)
        begin
                i_wb_ack  <= 1'b0;
                i_wb_err  <= 1'b0;
                wait_left = $unsigned($random(seed)) % 4;
        end
        else if (!i_reset && o_wb_stb === 1'b1)
        begin
                if (wait_left > 0)
                        wait_left = wait_left - 1;
                else
                begin
                        beat_adr_q.push_back(o_wb_adr);
                        beat_cti_q.push_back(o_wb_cti);
                        // Every beat is a full-word read.
                        if (o_wb_sel !== 4'hF)
                                report_mismatch("o_wb_sel", 32'hF, o_wb_sel);
                        if (o_wb_wen !== 1'b0)
                                report_mismatch("o_wb_wen", 32'h0, o_wb_wen);
                        if (err_en && o_wb_adr == err_addr)
                                i_wb_err <= 1'b1;
                        else
                        begin
                                i_wb_ack <= 1'b1;
                                i_wb_dat <= o_wb_adr ^ DATA_PATTERN;
                        end
                end
        end
end

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Verification failed");
                $finish;
        end
end

function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ DATA_PATTERN;
endfunction

function automatic logic [31:0] line_base(input logic [31:0] addr);
        return addr & ~(icache_pkg::DEF_CACHE_LINE - 1);
endfunction

task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, exp, act);
        errors = errors + 1;
endtask

task automatic report_problem(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        errors = errors + 1;
endtask

task automatic end_test(input string name, input int start_errors);
        tests = tests + 1;
        $display("Test %s finished with %0d errors", name, errors - start_errors);
endtask

// Holds i_rd until o_ack or o_err, then drops it on the next edge.
task automatic fetch_word(input logic [31:0] addr);
        @(posedge i_clk);
        beat_adr_q.delete();
        beat_cti_q.delete();
        bursts      = 0;
        rd_edges    = 0;
        rd_cyc_seen = 1'b0;
        rd_acked    = 1'b0;
        rd_erred    = 1'b0;
        i_address   <= addr;
        i_rd        <= 1'b1;
        while (!rd_acked && !rd_erred)
        begin
                @(posedge i_clk);
                rd_edges = rd_edges + 1;
                if (o_wb_cyc === 1'b1)
                        rd_cyc_seen = 1'b1;
                rd_acked = (o_ack === 1'b1);
                rd_erred = (o_err === 1'b1);
                rd_data  = o_dat;
        end
        i_rd <= 1'b0;
endtask

task automatic invalidate_all();
        @(posedge i_clk);
        i_cache_inv_req <= 1'b1;
        do
                @(posedge i_clk);
        while (o_cache_inv_done !== 1'b1);
        i_cache_inv_req <= 1'b0;
endtask

task automatic check_read_ok(input logic [31:0] addr);
        if (!rd_acked)
                report_problem($sformatf("read of %h ended without o_ack", addr));
        else if (rd_data !== expected_word(addr))
                report_mismatch("o_dat", expected_word(addr), rd_data);
endtask

task automatic check_refill_burst(input logic [31:0] addr);
        logic [31:0] exp_adr;
        logic [2:0]  exp_cti;
        if (bursts != 1 || beat_adr_q.size() != WORDS)
        begin
                report_problem($sformatf("expected one burst of %0d beats, saw %0d and %0d",
                                         WORDS, bursts, beat_adr_q.size()));
                return;
        end
        for (int i = 0; i < WORDS; i++)
        begin
                exp_adr = line_base(addr) + 4 * i;
                exp_cti = (i == WORDS - 1) ? icache_pkg::CTI_EOB : icache_pkg::CTI_INCR;
                if (beat_adr_q[i] !== exp_adr)
                        report_mismatch("o_wb_adr", exp_adr, beat_adr_q[i]);
                if (beat_cti_q[i] !== exp_cti)
                        report_mismatch("o_wb_cti", exp_cti, beat_cti_q[i]);
        end
endtask

task automatic check_single_beat(input logic [31:0] addr);
        if (bursts != 1 || beat_adr_q.size() != 1)
                report_problem($sformatf("uncached read of %h did not give one beat", addr));
        else if (beat_adr_q[0] !== addr)
                report_mismatch("o_wb_adr", addr, beat_adr_q[0]);
        else if (beat_cti_q[0] !== icache_pkg::CTI_EOB)
                report_mismatch("o_wb_cti", icache_pkg::CTI_EOB, beat_cti_q[0]);
endtask

task automatic test_miss_refill();
        int start_errors;
        start_errors = errors;
        fetch_word(ADDR_A);
        check_read_ok(ADDR_A);
        check_refill_burst(ADDR_A);
        end_test("miss_refill", start_errors);
endtask

task automatic test_hit();
        int          start_errors;
        logic [31:0] addr;
        start_errors = errors;
        for (int k = 0; k < WORDS; k++)
        begin
                addr = line_base(ADDR_A) + 4 * k;
                fetch_word(addr);
                check_read_ok(addr);
                // The request is sampled one edge after it is driven.
                if (rd_edges != HIT_EDGES + 1)
                        report_mismatch("o_ack latency", HIT_EDGES + 1, rd_edges);
                if (rd_cyc_seen)
                        report_problem($sformatf("o_wb_cyc rose during a hit on %h", addr));
        end
        end_test("hit", start_errors);
endtask

task automatic test_invalidate();
        int start_errors;
        start_errors = errors;
        invalidate_all();
        fetch_word(ADDR_A);
        check_read_ok(ADDR_A);
        check_refill_burst(ADDR_A);
        end_test("invalidate", start_errors);
endtask

task automatic test_cache_disabled();
        int          start_errors;
        logic [31:0] addr;
        start_errors = errors;
        @(posedge i_clk);
        i_cache_en <= 1'b0;
        for (int k = 0; k < 3; k++)
        begin
                addr = (k == 2) ? ADDR_A + 4 : ADDR_A;
                fetch_word(addr);
                check_read_ok(addr);
                check_single_beat(addr);
        end
        @(posedge i_clk);
        i_cache_en <= 1'b1;
        end_test("cache_disabled", start_errors);
endtask

task automatic test_bus_error();
        int start_errors;
        start_errors = errors;
        err_addr = ADDR_ERR;
        err_en   = 1'b1;
        fetch_word(ADDR_ERR - 4);
        if (!rd_erred)
                report_problem("refill over the error address did not end with o_err");
        if (rd_acked)
                report_problem("refill over the error address gave o_ack");
        err_en = 1'b0;
        fetch_word(ADDR_ERR - 4);
        check_read_ok(ADDR_ERR - 4);
        check_refill_burst(ADDR_ERR - 4);
        end_test("bus_error", start_errors);
endtask

task automatic test_back_pressure();
        int          start_errors;
        logic [31:0] addr;
        start_errors = errors;
        repeat (20)
        begin
                addr = $random(seed) & 32'h0000_07FC;
                fetch_word(addr);
                check_read_ok(addr);
        end
        end_test("back_pressure", start_errors);
endtask

initial
begin
        i_clk           = 1'b0;
        i_reset         = 1'b1;
        i_rd            = 1'b0;
        i_address       = '0;
        i_cache_en      = 1'b1;
        i_cache_inv_req = 1'b0;
        i_wb_dat        = '0;
        i_wb_ack        = 1'b0;
        i_wb_err        = 1'b0;
        err_en          = 1'b0;
        err_addr        = '0;
        wait_left       = 0;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        test_miss_refill();
        test_hit();
        test_invalidate();
        test_cache_disabled();
        test_bus_error();
        test_back_pressure();

        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0)
                $display("Verification passed");
        else
                $display("Verification failed");
        $finish;
end

endmodule

// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/icache_array_if.sv
hdl/icache_refill_if.sv
hdl/icache_req_stage.sv
hdl/icache_line_store.sv
hdl/icache_ctrl.sv
hdl/icache_wb_master.sv
hdl/icache_top.sv
tb/icache_tb_asserts.sv
tb/icache_tb.sv
